// File: logic/uart_pkg.sv
package uart_pkg;

  // **************************************************************************
  // baud timing
  // **************************************************************************
  localparam int CLK_FREQ = 50_000_000;           // system clock, Hz
  localparam int UART_BPS = 3_125_000;            // line rate, kept high for short sims
  localparam int BPS_CNT  = CLK_FREQ / UART_BPS;  // clocks per bit (16)
  localparam int BPS_HALF = BPS_CNT / 2;          // mid-bit sample point
  localparam int BPS_CW   = $clog2(BPS_CNT);      // bit-period counter width

  // **************************************************************************
  // echo buffer
  // **************************************************************************
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AW    = 4;                  // pointers wrap at FIFO_DEPTH

  // **************************************************************************
  // shared payloads
  // **************************************************************************

  // one received frame, as seen at the end of its stop bit
  typedef struct packed {
    logic [7:0] data;
    logic       frame_err;  // stop bit sampled low
  } rx_byte_t;

  // head of the buffer offered to the transmitter
  typedef struct packed {
    logic [7:0] data;
    logic       avail;      // buffer not empty
  } tx_req_t;

endpackage

// File: logic/uart_rx.sv
`timescale 1ns/1ns

module uart_rx (
  input  logic               sys_clk,
  input  logic               sys_rst_n,
  input  logic               uart_rxd,
  output uart_pkg::rx_byte_t rx_data,
  output logic               rx_done,
  output logic               frame_err
);

  import uart_pkg::*;

  logic              rxd_d0;
  logic              rxd_d1;
  logic              start_flag;
  logic              rx_flag;     // frame in progress
  logic [BPS_CW-1:0] clk_cnt;
  logic [3:0]        bit_cnt;     // 0 start, 1..8 data, 9 stop
  logic [7:0]        rx_shift;
  logic              bit_mid;
  logic              stop_mid;

  // **************************************************************************
  // input synchronizer and start detect
  // **************************************************************************

  // both flops come up idle high so reset release is not seen as a start
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      rxd_d0 <= 1'b1;
      rxd_d1 <= 1'b1;
    end else begin
      rxd_d0 <= uart_rxd;
      rxd_d1 <= rxd_d0;
    end
  end

  // falling edge, ignored while a frame is being received
  assign start_flag = rxd_d1 & ~rxd_d0 & ~rx_flag;

  assign bit_mid  = rx_flag && (clk_cnt == BPS_CW'(BPS_HALF));
  assign stop_mid = bit_mid && (bit_cnt == 4'd9);

  // **************************************************************************
  // frame timing
  // **************************************************************************
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      rx_flag <= 1'b0;
    end else if (start_flag) begin
      rx_flag <= 1'b1;
    end else if (stop_mid) begin
      rx_flag <= 1'b0;  // back to idle halfway through stop
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      clk_cnt <= '0;
    end else if (!rx_flag) begin
      clk_cnt <= '0;
    end else if (clk_cnt == BPS_CW'(BPS_CNT - 1)) begin
      clk_cnt <= '0;
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      bit_cnt <= 4'd0;
    end else if (!rx_flag) begin
      bit_cnt <= 4'd0;
    end else if (clk_cnt == BPS_CW'(BPS_CNT - 1)) begin
      bit_cnt <= bit_cnt + 1'b1;  // next bit period
    end
  end

  // **************************************************************************
  // data capture
  // **************************************************************************

  // LSB arrives first, so shift in from the top
  always_ff @(posedge sys_clk) begin
    if (bit_mid && (bit_cnt >= 4'd1) && (bit_cnt <= 4'd8)) begin
      rx_shift <= {rxd_d1, rx_shift[7:1]};
    end
  end

  // one of the two strobes per frame, the cycle after stop is sampled
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      rx_done   <= 1'b0;
      frame_err <= 1'b0;
      rx_data   <= '0;
    end else begin
      rx_done   <= stop_mid & rxd_d1;
      frame_err <= stop_mid & ~rxd_d1;
      if (stop_mid) begin
        rx_data.data      <= rx_shift;
        rx_data.frame_err <= ~rxd_d1;  // low stop bit
      end
    end
  end

endmodule

// File: logic/byte_fifo.sv
`timescale 1ns/1ns

module byte_fifo (
  input  logic              sys_clk,
  input  logic              sys_rst_n,
  input  logic              push,
  input  logic [7:0]        push_data,
  input  logic              pop,
  output uart_pkg::tx_req_t tx_req,
  output logic              overflow
);

  import uart_pkg::*;

  logic [7:0]         mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;      // occupancy, 0..FIFO_DEPTH
  logic               full;
  logic               empty;
  logic               do_push;
  logic               do_pop;

  assign full    = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
  assign empty   = (count == '0);
  assign do_push = push & ~full;  // full buffer drops the byte
  assign do_pop  = pop & ~empty;

  // first-word fall-through head
  assign tx_req.data  = mem[rd_ptr];
  assign tx_req.avail = ~empty;

  // **************************************************************************
  // storage and pointers
  // **************************************************************************
  always_ff @(posedge sys_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      count <= '0;
    end else begin
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle, or push and pop together
      endcase
    end
  end

  // sticky until reset
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      overflow <= 1'b0;
    end else if (push && full) begin
      overflow <= 1'b1;
    end
  end

endmodule

// File: logic/uart_tx.sv
`timescale 1ns/1ns

module uart_tx (
  input  logic              sys_clk,
  input  logic              sys_rst_n,
  input  uart_pkg::tx_req_t tx_req,
  input  logic              cts_n,
  output logic              pop,
  output logic              uart_txd,
  output logic              tx_busy
);

  import uart_pkg::*;

  logic [8:0]        tx_shift;    // bits still to go: data then stop
  logic [BPS_CW-1:0] clk_cnt;
  logic [3:0]        bit_cnt;     // bit currently on the line
  logic              bit_end;
  logic              start_frame;

  // flow control is only looked at between frames
  assign start_frame = ~tx_busy & tx_req.avail & ~cts_n;
  assign pop         = start_frame;

  assign bit_end = tx_busy && (clk_cnt == BPS_CW'(BPS_CNT - 1));

  // **************************************************************************
  // bit-period counter
  // **************************************************************************
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      clk_cnt <= '0;
    end else if (!tx_busy || bit_end) begin
      clk_cnt <= '0;
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  // **************************************************************************
  // frame shifter
  // **************************************************************************
  always_ff @(posedge sys_clk) begin
    if (start_frame) begin
      tx_shift <= {1'b1, tx_req.data};  // stop bit on top
    end else if (bit_end) begin
      tx_shift <= {1'b1, tx_shift[8:1]};
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      tx_busy  <= 1'b0;
      uart_txd <= 1'b1;  // line idles high
      bit_cnt  <= 4'd0;
    end else if (start_frame) begin
      tx_busy  <= 1'b1;
      uart_txd <= 1'b0;  // start bit
      bit_cnt  <= 4'd0;
    end else if (bit_end) begin
      if (bit_cnt == 4'd9) begin
        // stop bit done, line already high
        tx_busy <= 1'b0;
      end else begin
        uart_txd <= tx_shift[0];
        bit_cnt  <= bit_cnt + 1'b1;
      end
    end
  end

endmodule

// File: logic/uart_echo.sv
`timescale 1ns/1ns

module uart_echo (
  input  logic               sys_clk,
  input  logic               sys_rst_n,
  input  logic               uart_rxd,
  input  logic               cts_n,
  output logic               uart_txd,
  output uart_pkg::rx_byte_t rx_data,
  output logic               rx_done,
  output logic               frame_err,
  output logic               overflow,
  output logic               tx_busy
);

  import uart_pkg::*;

  tx_req_t tx_req;  // buffer head
  logic    tx_pop;

  // receiver, framing errors never reach the buffer
  uart_rx u_uart_rx (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .uart_rxd  (uart_rxd),
    .rx_data   (rx_data),
    .rx_done   (rx_done),
    .frame_err (frame_err)
  );

  byte_fifo u_byte_fifo (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .push      (rx_done),
    .push_data (rx_data.data),
    .pop       (tx_pop),
    .tx_req    (tx_req),
    .overflow  (overflow)
  );

  // transmitter, held off between frames by cts_n
  uart_tx u_uart_tx (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .tx_req    (tx_req),
    .cts_n     (cts_n),
    .pop       (tx_pop),
    .uart_txd  (uart_txd),
    .tx_busy   (tx_busy)
  );

endmodule

// File: sim/uart_echo_assert.sv
`timescale 1ns/1ns

module uart_echo_assert (
  input logic sys_clk,
  input logic sys_rst_n,
  input logic uart_txd,
  input logic tx_busy,
  input logic rx_done,
  input logic frame_err,
  input logic overflow
);

  // line idles high outside a frame
  a_txd_idle_high: assert property (
    @(posedge sys_clk) disable iff (!sys_rst_n) !tx_busy |-> uart_txd
  ) else $error("uart_txd low while tx_busy is low");

  a_one_strobe: assert property (
    @(posedge sys_clk) disable iff (!sys_rst_n) !(rx_done && frame_err)
  ) else $error("rx_done and frame_err high together");

  // sticky flag, only reset clears it
  a_overflow_sticky: assert property (
    @(posedge sys_clk) disable iff (!sys_rst_n) !$fell(overflow)
  ) else $error("overflow fell without reset");

  a_done_single: assert property (
    @(posedge sys_clk) disable iff (!sys_rst_n) rx_done |=> !rx_done
  ) else $error("rx_done high two cycles in a row");

endmodule

bind uart_echo uart_echo_assert u_uart_echo_assert (
  .sys_clk   (sys_clk),
  .sys_rst_n (sys_rst_n),
  .uart_txd  (uart_txd),
  .tx_busy   (tx_busy),
  .rx_done   (rx_done),
  .frame_err (frame_err),
  .overflow  (overflow)
);

// File: sim/tb_uart_echo.sv
`timescale 1ns/1ns

module tb_uart_echo;

  import uart_pkg::*;

  localparam int BURST_LEN    = 200;
  localparam int ERR_LEN      = 30;
  localparam int HOLD_LEN     = 20;
  localparam int TOTAL_FRAMES = 1 + BURST_LEN + ERR_LEN + HOLD_LEN;
  localparam int FRAME_CYC    = 10 * BPS_CNT;
  // three nominal frame times per frame at 10 ns, plus slack for reset and drains
  localparam longint WATCHDOG_NS = longint'(TOTAL_FRAMES) * FRAME_CYC * 10 * 3 + 200_000;

  logic     sys_clk;
  logic     sys_rst_n;
  logic     uart_rxd;
  logic     cts_n;
  logic     uart_txd;
  rx_byte_t rx_data;
  logic     rx_done;
  logic     frame_err;
  logic     overflow;
  logic     tx_busy;

  integer     seed;
  int         value_errs;
  int         other_errs;
  int         rx_done_cnt;
  int         frame_err_cnt;
  int         echo_cnt;
  int         held_cnt;   // bytes the model holds while cts_n is high
  logic [8:0] sent_q[$];  // {bad stop, data} per frame on uart_rxd
  logic [7:0] exp_q[$];   // bytes expected back on uart_txd

  uart_echo u_uart_echo (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .uart_rxd  (uart_rxd),
    .cts_n     (cts_n),
    .uart_txd  (uart_txd),
    .rx_data   (rx_data),
    .rx_done   (rx_done),
    .frame_err (frame_err),
    .overflow  (overflow),
    .tx_busy   (tx_busy)
  );

  always #5 sys_clk = ~sys_clk;

  // **************************************************************************
  // helpers, all entered and left 1 ns after a rising edge
  // **************************************************************************
  task automatic idle(input int cycles);
    if (cycles > 0) begin
      repeat (cycles) @(posedge sys_clk);
      #1;
    end
  endtask

  task automatic check_level(input string what, input logic got, input logic want);
    if (got !== want) begin
      value_errs++;
      $display("FAILED %0t: %s is %b, expected %b", $time, what, got, want);
    end
  endtask

  // start, 8 data bits LSB first, stop
  task automatic send_frame(input logic [7:0] data, input logic bad_stop);
    logic [9:0] frame;
    int         i;
    frame = {~bad_stop, data, 1'b0};
    for (i = 0; i < 10; i++) begin
      uart_rxd = frame[i];
      idle(BPS_CNT);
    end
    uart_rxd = 1'b1;
  endtask

  task automatic send_byte(input logic [7:0] data, input logic bad_stop);
    sent_q.push_back({bad_stop, data});
    if (!bad_stop) begin
      if (cts_n === 1'b0) begin
        exp_q.push_back(data);
      end else if (held_cnt < FIFO_DEPTH) begin
        exp_q.push_back(data);
        held_cnt++;
      end  // else dropped by a full buffer
    end
    send_frame(data, bad_stop);
    if (bad_stop) begin
      idle(BPS_CNT);  // line must go high again before the next start edge
    end
  endtask

  task automatic wait_received(input int max_cycles);
    int n;
    n = 0;
    while (sent_q.size() != 0 && n < max_cycles) begin
      idle(1);
      n++;
    end
    if (sent_q.size() != 0) begin
      other_errs++;
      $display("receiver gave no result for %0d frames by %0t", sent_q.size(), $time);
      sent_q.delete();
    end
  endtask

  task automatic wait_drain(input int max_cycles);
    int n;
    wait_received(max_cycles);
    n = 0;
    while ((exp_q.size() != 0 || tx_busy === 1'b1) && n < max_cycles) begin
      idle(1);
      n++;
    end
    if (exp_q.size() != 0) begin
      other_errs++;
      $display("missing echo: %0d bytes never came back by %0t", exp_q.size(), $time);
      exp_q.delete();
    end
  endtask

  task automatic print_counts();
    $display("errors: %0d wrong values, %0d other; %0d rx_done, %0d frame_err, %0d echoed",
             value_errs, other_errs, rx_done_cnt, frame_err_cnt, echo_cnt);
  endtask

  // **************************************************************************
  // receive side monitor, sampled on the falling edge
  // **************************************************************************
  always @(negedge sys_clk) begin : rx_monitor
    logic [8:0] want;
    if (sys_rst_n === 1'b1) begin
      if (rx_done === 1'b1) begin
        rx_done_cnt++;
        if (sent_q.size() == 0) begin
          other_errs++;
          $display("rx_done pulsed at %0t with no frame sent", $time);
        end else begin
          want = sent_q.pop_front();
          if (want[8] || rx_data.data !== want[7:0] || rx_data.frame_err !== 1'b0) begin
            value_errs++;
            $display("FAILED %0t: rx_done with data %h, expected %h bad_stop %b",
                     $time, rx_data.data, want[7:0], want[8]);
          end
        end
      end
      if (frame_err === 1'b1) begin
        frame_err_cnt++;
        if (sent_q.size() == 0) begin
          other_errs++;
          $display("frame_err pulsed at %0t with no frame sent", $time);
        end else begin
          want = sent_q.pop_front();
          if (!want[8] || rx_data.frame_err !== 1'b1) begin
            value_errs++;
            $display("FAILED %0t: frame_err on frame %h with a good stop bit",
                     $time, want[7:0]);
          end
        end
      end
      if (cts_n === 1'b1 && tx_busy === 1'b1) begin
        value_errs++;
        $display("FAILED %0t: tx_busy high while cts_n is high", $time);
      end
    end
  end

  // **************************************************************************
  // transmit side monitor
  // **************************************************************************
  initial begin : tx_monitor
    logic [7:0] got;
    logic [7:0] want;
    int         i;
    wait (sys_rst_n === 1'b1);
    forever begin
      @(negedge sys_clk);
      if (uart_txd === 1'b0) begin
        repeat (BPS_HALF) @(negedge sys_clk);  // middle of start bit
        check_level("start bit on uart_txd", uart_txd, 1'b0);
        for (i = 0; i < 8; i++) begin
          repeat (BPS_CNT) @(negedge sys_clk);
          got[i] = uart_txd;
        end
        repeat (BPS_CNT) @(negedge sys_clk);
        check_level("stop bit on uart_txd", uart_txd, 1'b1);
        echo_cnt++;
        if (exp_q.size() == 0) begin
          other_errs++;
          $display("unexpected byte %h on uart_txd at %0t", got, $time);
        end else begin
          want = exp_q.pop_front();
          if (got !== want) begin
            value_errs++;
            $display("FAILED %0t: echoed %h, expected %h", $time, got, want);
          end
        end
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: run still going after %0d ns", WATCHDOG_NS);
    print_counts();
    $display("tests failed");
    $finish;
  end

  // **************************************************************************
  // stimulus
  // **************************************************************************
  initial begin : stimulus
    integer     r;
    logic [7:0] data;
    logic       bad;
    int         k;
    int         cnt0;
    int         n_bad;
    seed          = 32'h07aa_f393;
    value_errs    = 0;
    other_errs    = 0;
    rx_done_cnt   = 0;
    frame_err_cnt = 0;
    echo_cnt      = 0;
    held_cnt      = 0;
    sys_clk       = 1'b0;
    sys_rst_n     = 1'b0;
    uart_rxd      = 1'b1;
    cts_n         = 1'b0;
    repeat (16) @(posedge sys_clk);
    #1;
    sys_rst_n = 1'b1;
    idle(4);

    // idle state out of reset
    check_level("uart_txd", uart_txd, 1'b1);
    check_level("rx_done", rx_done, 1'b0);
    check_level("frame_err", frame_err, 1'b0);
    check_level("overflow", overflow, 1'b0);
    check_level("tx_busy", tx_busy, 1'b0);
    if (rx_data !== '0) begin
      value_errs++;
      $display("FAILED %0t: rx_data is %h after reset", $time, rx_data);
    end

    // single byte
    r    = $random(seed);
    data = r[7:0];
    cnt0 = rx_done_cnt;
    send_byte(data, 1'b0);
    wait_drain(3 * FRAME_CYC);
    if (rx_done_cnt != cnt0 + 1) begin
      value_errs++;
      $display("FAILED %0t: %0d rx_done pulses for one frame", $time, rx_done_cnt - cnt0);
    end
    if (rx_data.data !== data) begin
      value_errs++;
      $display("FAILED %0t: rx_data.data %h, expected %h", $time, rx_data.data, data);
    end

    // burst with random gaps
    for (k = 0; k < BURST_LEN; k++) begin
      r    = $random(seed);
      data = r[7:0];
      send_byte(data, 1'b0);
      r = $random(seed);
      idle(r & 31);
    end
    wait_drain(4 * FRAME_CYC);
    check_level("overflow after burst", overflow, 1'b0);

    // bad stop bits mixed in
    cnt0  = frame_err_cnt;
    n_bad = 0;
    for (k = 0; k < ERR_LEN; k++) begin
      r    = $random(seed);
      data = r[7:0];
      r    = $random(seed);
      bad  = ((k % 6) == 3) || ((r & 7) == 0);
      if (bad) begin
        n_bad++;
      end
      send_byte(data, bad);
      idle(r & 15);
    end
    wait_drain(4 * FRAME_CYC);
    if (frame_err_cnt - cnt0 != n_bad) begin
      value_errs++;
      $display("FAILED %0t: %0d frame_err pulses, expected %0d",
               $time, frame_err_cnt - cnt0, n_bad);
    end

    // hold the transmitter off and overfill the buffer
    cts_n    = 1'b1;
    held_cnt = 0;
    for (k = 0; k < HOLD_LEN; k++) begin
      r    = $random(seed);
      data = r[7:0];
      send_byte(data, 1'b0);
      r = $random(seed);
      idle(r & 31);
    end
    wait_received(2 * FRAME_CYC);
    check_level("tx_busy under cts_n", tx_busy, 1'b0);
    check_level("overflow after overfill", overflow, 1'b1);
    cts_n = 1'b0;
    wait_drain((FIFO_DEPTH + 4) * FRAME_CYC);
    check_level("overflow after drain", overflow, 1'b1);

    idle(3 * FRAME_CYC);  // room for any stray echo
    print_counts();
    if (value_errs == 0 && other_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: compile.f
logic/uart_pkg.sv
logic/uart_rx.sv
logic/byte_fifo.sv
logic/uart_tx.sv
logic/uart_echo.sv
sim/uart_echo_assert.sv
sim/tb_uart_echo.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the echo testbench with Verilator, run it, then scan the log

set -o pipefail
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -j 0 \
  --top-module tb_uart_echo \
  -f compile.f \
  -o sim_uart_echo \
  || { echo "verilator build failed"; exit 1; }

./obj_dir/sim_uart_echo 2>&1 | tee "$LOG" \
  || { echo "simulation ended with an error status, see $LOG"; exit 1; }

grep -q "tests failed" "$LOG" \
  && { echo "FAIL: see $LOG"; exit 1; }

echo "PASS"
exit 0
